// ==== logic/mips_isa_pkg.sv ====
// MIPS32 integer subset decoded by the pipelined core
// encodings outside this list are executed as a nop
`default_nettype none

package mips_isa_pkg;

    localparam int word_bits = 32;
    localparam int reg_bits  = 5;
    localparam int op_bits   = 6;
    localparam int fn_bits   = 6;

    typedef logic [word_bits-1:0] word_t;
    typedef logic [reg_bits-1:0]  reg_addr_t;

    // ********************
    // opcodes, instr[31:26]
    localparam logic [op_bits-1:0] op_rtype = 6'h00;
    localparam logic [op_bits-1:0] op_beq   = 6'h04;
    localparam logic [op_bits-1:0] op_bne   = 6'h05;
    localparam logic [op_bits-1:0] op_addiu = 6'h09;
    localparam logic [op_bits-1:0] op_lui   = 6'h0f;
    localparam logic [op_bits-1:0] op_lw    = 6'h23;
    localparam logic [op_bits-1:0] op_sw    = 6'h2b;

    // ********************
    // function codes of op_rtype, instr[5:0]
    localparam logic [fn_bits-1:0] fn_addu = 6'h21;
    localparam logic [fn_bits-1:0] fn_subu = 6'h23;
    localparam logic [fn_bits-1:0] fn_and  = 6'h24;
    localparam logic [fn_bits-1:0] fn_or   = 6'h25;
    localparam logic [fn_bits-1:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,    // signed
        alu_lui     // operand b moved to the upper half
    } alu_op_t;

endpackage

`default_nettype wire

// ==== logic/pipe_ctrl_pkg.sv ====
// hazard and forwarding encodings shared by control and the datapath
`default_nettype none

package pipe_ctrl_pkg;

    // source of an execute stage operand
    typedef enum logic [1:0] {
        fwd_none   = 2'd0,  // value latched in the D/E register
        fwd_from_m = 2'd1,  // alu result now in memory stage
        fwd_from_w = 2'd2   // writeback result
    } fwd_e_t;

    // word loaded into F/D on flush, decodes to sll r0,r0,0
    localparam logic [31:0] nop_instr = 32'h0000_0000;

    // never a forwarding target
    localparam logic [4:0] zero_reg = 5'd0;

endpackage

`default_nettype wire

// ==== logic/pcpu_control.sv ====
// decoder for the instruction in D plus the hazard unit
// branch operands come from M or from the register file only,
// a producer still in E (or a load in M) costs a bubble
`timescale 1ns/1ps
`default_nettype none

module pcpu_control (
    input  logic [mips_isa_pkg::op_bits-1:0] op_d,
    input  logic [mips_isa_pkg::fn_bits-1:0] funct_d,
    input  mips_isa_pkg::reg_addr_t          rs_d,
    input  mips_isa_pkg::reg_addr_t          rt_d,
    input  logic                             regs_equal_d,
    input  mips_isa_pkg::reg_addr_t          write_reg_e,
    input  mips_isa_pkg::reg_addr_t          write_reg_m,
    input  mips_isa_pkg::reg_addr_t          write_reg_w,
    input  logic                             reg_write_e,
    input  logic                             reg_write_m,
    input  logic                             reg_write_w,
    input  logic                             mem_to_reg_e,
    input  logic                             mem_to_reg_m,
    input  mips_isa_pkg::reg_addr_t          rs_e,
    input  mips_isa_pkg::reg_addr_t          rt_e,
    input  logic                             mem_busy,
    output logic                             reg_write_d,
    output logic                             mem_to_reg_d,
    output logic                             mem_write_d,
    output logic                             alu_src_d,
    output logic                             reg_dst_d,
    output mips_isa_pkg::alu_op_t            alu_op_d,
    output logic                             pc_src_d,
    output logic                             stall_fd,
    output logic                             flush_d,
    output logic                             flush_e,
    output logic                             stall_emw,
    output logic                             fwd_a_d,
    output logic                             fwd_b_d,
    output pipe_ctrl_pkg::fwd_e_t            fwd_a_e,
    output pipe_ctrl_pkg::fwd_e_t            fwd_b_e
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic beq_d, bne_d;
    logic load_use_stall, branch_stall;

    // ********************
    // decoder
    always_comb begin
        reg_write_d  = 1'b0;
        mem_to_reg_d = 1'b0;
        mem_write_d  = 1'b0;
        alu_src_d    = 1'b0;   // 1: immediate as operand b
        reg_dst_d    = 1'b0;   // 1: rd, 0: rt
        alu_op_d     = alu_add;
        beq_d        = 1'b0;
        bne_d        = 1'b0;
        case (op_d)
            op_rtype: begin
                reg_dst_d   = 1'b1;
                reg_write_d = 1'b1;
                case (funct_d)
                    fn_addu: alu_op_d = alu_add;
                    fn_subu: alu_op_d = alu_sub;
                    fn_and:  alu_op_d = alu_and;
                    fn_or:   alu_op_d = alu_or;
                    fn_slt:  alu_op_d = alu_slt;
                    default: reg_write_d = 1'b0;  // unknown funct
                endcase
            end
            op_addiu: begin
                reg_write_d = 1'b1;
                alu_src_d   = 1'b1;
            end
            op_lui: begin
                reg_write_d = 1'b1;
                alu_src_d   = 1'b1;
                alu_op_d    = alu_lui;
            end
            op_lw: begin
                reg_write_d  = 1'b1;
                alu_src_d    = 1'b1;
                mem_to_reg_d = 1'b1;
            end
            op_sw: begin
                alu_src_d   = 1'b1;
                mem_write_d = 1'b1;
            end
            op_beq: beq_d = 1'b1;
            op_bne: bne_d = 1'b1;
            default: ;             // nop
        endcase
    end

    assign pc_src_d = (beq_d & regs_equal_d) | (bne_d & ~regs_equal_d);

    // ********************
    // forwarding, M wins over W
    assign fwd_a_d = (rs_d != zero_reg) && reg_write_m && (rs_d == write_reg_m);
    assign fwd_b_d = (rt_d != zero_reg) && reg_write_m && (rt_d == write_reg_m);

    assign fwd_a_e = (rs_e == zero_reg)                   ? fwd_none   :
                     (reg_write_m && rs_e == write_reg_m) ? fwd_from_m :
                     (reg_write_w && rs_e == write_reg_w) ? fwd_from_w : fwd_none;
    assign fwd_b_e = (rt_e == zero_reg)                   ? fwd_none   :
                     (reg_write_m && rt_e == write_reg_m) ? fwd_from_m :
                     (reg_write_w && rt_e == write_reg_w) ? fwd_from_w : fwd_none;

    // ********************
    // stalls
    assign load_use_stall = mem_to_reg_e && (rs_d == write_reg_e || rt_d == write_reg_e);
    assign branch_stall   = (beq_d || bne_d) &&
                            ((reg_write_e && (rs_d == write_reg_e || rt_d == write_reg_e)) ||
                             (mem_to_reg_m && (rs_d == write_reg_m || rt_d == write_reg_m)));

    assign stall_emw = mem_busy;                          // whole pipe waits on memory
    assign flush_e   = load_use_stall || branch_stall;    // bubble into E
    assign stall_fd  = flush_e || mem_busy;
    assign flush_d   = pc_src_d && !stall_fd;             // kill the fetched successor

endmodule

`default_nettype wire

// ==== logic/pcpu_fetch_decode.sv ====
// pc, F/D register, decode datapath and D/E register
// branch target and compare are resolved here, no delay slot
`timescale 1ns/1ps
`default_nettype none

module pcpu_fetch_decode #(
    parameter mips_isa_pkg::word_t reset_pc = '0
) (
    input  logic                              clk,
    input  logic                              reset,
    output mips_isa_pkg::word_t               im_addr,
    input  mips_isa_pkg::word_t               im_data,
    output mips_isa_pkg::word_t               pc_f,
    input  logic                              pc_src_d,
    input  logic                              stall_fd,
    input  logic                              flush_d,
    input  logic                              flush_e,
    input  logic                              stall_emw,
    input  logic                              fwd_a_d,
    input  logic                              fwd_b_d,
    input  mips_isa_pkg::word_t               alu_result_m,
    input  mips_isa_pkg::word_t               rd1_d,
    input  mips_isa_pkg::word_t               rd2_d,
    input  logic                              reg_write_d,
    input  logic                              mem_to_reg_d,
    input  logic                              mem_write_d,
    input  logic                              alu_src_d,
    input  logic                              reg_dst_d,
    input  mips_isa_pkg::alu_op_t             alu_op_d,
    output logic [mips_isa_pkg::op_bits-1:0]  op_d,
    output logic [mips_isa_pkg::fn_bits-1:0]  funct_d,
    output mips_isa_pkg::reg_addr_t           rs_d,
    output mips_isa_pkg::reg_addr_t           rt_d,
    output logic                              regs_equal_d,
    output mips_isa_pkg::word_t               rd1_e,
    output mips_isa_pkg::word_t               rd2_e,
    output mips_isa_pkg::word_t               imm_e,
    output mips_isa_pkg::reg_addr_t           rs_e,
    output mips_isa_pkg::reg_addr_t           rt_e,
    output mips_isa_pkg::reg_addr_t           rd_e,
    output logic                              reg_write_e,
    output logic                              mem_to_reg_e,
    output logic                              mem_write_e,
    output logic                              alu_src_e,
    output logic                              reg_dst_e,
    output mips_isa_pkg::alu_op_t             alu_op_e
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    word_t     pc_plus4_f, instr_d, pc_plus4_d;
    word_t     imm_d, pc_branch_d, cmp_a_d, cmp_b_d;
    reg_addr_t rd_d;

    // ********************
    // F
    assign pc_plus4_f = pc_f + 32'd4;
    assign im_addr    = {2'b00, pc_f[31:2]};  // word addressed rom

    always_ff @(posedge clk) begin
        if (reset)
            pc_f <= reset_pc;
        else if (!stall_fd)
            pc_f <= pc_src_d ? pc_branch_d : pc_plus4_f;
    end

    always_ff @(posedge clk) begin
        if (reset || flush_d)
            instr_d <= nop_instr;
        else if (!stall_fd)
            instr_d <= im_data;
    end

    always_ff @(posedge clk) begin
        if (!stall_fd)
            pc_plus4_d <= pc_plus4_f;
    end

    // ********************
    // D
    assign op_d    = instr_d[31:26];
    assign rs_d    = instr_d[25:21];
    assign rt_d    = instr_d[20:16];
    assign rd_d    = instr_d[15:11];
    assign funct_d = instr_d[5:0];
    assign imm_d   = {{16{instr_d[15]}}, instr_d[15:0]};

    assign pc_branch_d = pc_plus4_d + {imm_d[29:0], 2'b00};

    // early compare, W is covered by the write-through register file
    assign cmp_a_d      = fwd_a_d ? alu_result_m : rd1_d;
    assign cmp_b_d      = fwd_b_d ? alu_result_m : rd2_d;
    assign regs_equal_d = (cmp_a_d == cmp_b_d);

    // D/E, a flush leaves a bubble unless memory holds the stage
    always_ff @(posedge clk) begin
        if (reset || (flush_e && !stall_emw)) begin
            reg_write_e  <= 1'b0;
            mem_to_reg_e <= 1'b0;
            mem_write_e  <= 1'b0;
        end else if (!stall_emw) begin
            reg_write_e  <= reg_write_d;
            mem_to_reg_e <= mem_to_reg_d;
            mem_write_e  <= mem_write_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_emw) begin
            rd1_e     <= rd1_d;
            rd2_e     <= rd2_d;
            imm_e     <= imm_d;
            rs_e      <= rs_d;
            rt_e      <= rt_d;
            rd_e      <= rd_d;
            alu_src_e <= alu_src_d;
            reg_dst_e <= reg_dst_d;
            alu_op_e  <= alu_op_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pcpu_regfile.sv ====
// 32 x 32 register file, r0 reads as zero
// a write shows on the read ports in the same cycle
`timescale 1ns/1ps
`default_nettype none

module pcpu_regfile (
    input  logic                    clk,
    input  mips_isa_pkg::reg_addr_t a0,   // debug port
    input  mips_isa_pkg::reg_addr_t a1,
    input  mips_isa_pkg::reg_addr_t a2,
    input  mips_isa_pkg::reg_addr_t a3,
    input  mips_isa_pkg::word_t     wd3,
    input  logic                    we3,
    output mips_isa_pkg::word_t     rd1,
    output mips_isa_pkg::word_t     rd2,
    input  mips_isa_pkg::word_t     pc_f,
    output mips_isa_pkg::word_t     reg_data
);
    import mips_isa_pkg::*;

    word_t rf [0:31];
    word_t rd0;

    always_ff @(posedge clk) begin
        if (we3)
            rf[a3] <= wd3;
    end

    assign rd0 = (we3 && a0 == a3) ? wd3 : rf[a0];
    assign rd1 = (a1 == '0) ? '0 : (we3 && a1 == a3) ? wd3 : rf[a1];
    assign rd2 = (a2 == '0) ? '0 : (we3 && a2 == a3) ? wd3 : rf[a2];

    assign reg_data = (a0 == '0) ? pc_f : rd0;   // address 0 shows the pc

endmodule

`default_nettype wire

// ==== logic/pcpu_execute.sv ====
// execute stage: operand forwarding, ALU and the E/M register
`timescale 1ns/1ps
`default_nettype none

module pcpu_execute (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_emw,
    input  mips_isa_pkg::word_t     rd1_e,
    input  mips_isa_pkg::word_t     rd2_e,
    input  mips_isa_pkg::word_t     imm_e,
    input  mips_isa_pkg::reg_addr_t rt_e,
    input  mips_isa_pkg::reg_addr_t rd_e,
    input  logic                    reg_write_e,
    input  logic                    mem_to_reg_e,
    input  logic                    mem_write_e,
    input  logic                    alu_src_e,
    input  logic                    reg_dst_e,
    input  mips_isa_pkg::alu_op_t   alu_op_e,
    input  pipe_ctrl_pkg::fwd_e_t   fwd_a_e,
    input  pipe_ctrl_pkg::fwd_e_t   fwd_b_e,
    input  mips_isa_pkg::word_t     result_w,
    output mips_isa_pkg::reg_addr_t write_reg_e,
    output mips_isa_pkg::word_t     alu_result_m,
    output mips_isa_pkg::word_t     write_data_m,
    output mips_isa_pkg::reg_addr_t write_reg_m,
    output logic                    reg_write_m,
    output logic                    mem_to_reg_m,
    output logic                    mem_write_m
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    word_t src_a_e, src_b_e, write_data_e, alu_result_e;

    assign src_a_e      = (fwd_a_e == fwd_from_m) ? alu_result_m :
                          (fwd_a_e == fwd_from_w) ? result_w : rd1_e;
    assign write_data_e = (fwd_b_e == fwd_from_m) ? alu_result_m :
                          (fwd_b_e == fwd_from_w) ? result_w : rd2_e;   // also store data
    assign src_b_e      = alu_src_e ? imm_e : write_data_e;

    always_comb begin
        case (alu_op_e)
            alu_sub: alu_result_e = src_a_e - src_b_e;
            alu_and: alu_result_e = src_a_e & src_b_e;
            alu_or:  alu_result_e = src_a_e | src_b_e;
            alu_slt: alu_result_e = {31'b0, $signed(src_a_e) < $signed(src_b_e)};
            alu_lui: alu_result_e = {src_b_e[15:0], 16'h0000};
            default: alu_result_e = src_a_e + src_b_e;
        endcase
    end

    assign write_reg_e = reg_dst_e ? rd_e : rt_e;

    // ********************
    // E/M
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_m  <= 1'b0;
            mem_to_reg_m <= 1'b0;
            mem_write_m  <= 1'b0;
        end else if (!stall_emw) begin
            reg_write_m  <= reg_write_e;
            mem_to_reg_m <= mem_to_reg_e;
            mem_write_m  <= mem_write_e;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_emw) begin
            alu_result_m <= alu_result_e;
            write_data_m <= write_data_e;
            write_reg_m  <= write_reg_e;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pcpu_mem_wb.sv ====
// memory and writeback stages
// the M request stays on the bus until dm_ready, rdata is taken on that edge
`timescale 1ns/1ps
`default_nettype none

module pcpu_mem_wb (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_emw,
    input  mips_isa_pkg::word_t     alu_result_m,
    input  mips_isa_pkg::word_t     write_data_m,
    input  mips_isa_pkg::reg_addr_t write_reg_m,
    input  logic                    reg_write_m,
    input  logic                    mem_to_reg_m,
    input  logic                    mem_write_m,
    input  mips_isa_pkg::word_t     dm_rdata,
    input  logic                    dm_ready,
    output mips_isa_pkg::word_t     dm_addr,
    output logic                    dm_we,
    output mips_isa_pkg::word_t     dm_wdata,
    output logic                    dm_valid,
    output logic                    mem_busy,
    output mips_isa_pkg::reg_addr_t write_reg_w,
    output logic                    reg_write_w,
    output mips_isa_pkg::word_t     result_w
);
    import mips_isa_pkg::*;

    word_t read_data_w, alu_result_w;
    logic  mem_to_reg_w;

    assign dm_addr  = alu_result_m;              // byte address
    assign dm_we    = mem_write_m;
    assign dm_wdata = write_data_m;
    assign dm_valid = mem_write_m | mem_to_reg_m;
    assign mem_busy = dm_valid & ~dm_ready;

    // M/W
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else if (!stall_emw) begin
            reg_write_w  <= reg_write_m;
            mem_to_reg_w <= mem_to_reg_m;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_emw) begin
            read_data_w  <= dm_rdata;
            alu_result_w <= alu_result_m;
            write_reg_w  <= write_reg_m;
        end
    end

    assign result_w = mem_to_reg_w ? read_data_w : alu_result_w;

endmodule

`default_nettype wire

// ==== logic/pcpu_top.sv ====
// five stage MIPS integer core, no delay slot, no exceptions
// im_data must answer in the same cycle as im_addr (word address)
// data side holds its request until dm_ready is seen high
`timescale 1ns/1ps
`default_nettype none

module pcpu_top #(
    parameter mips_isa_pkg::word_t reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  mips_isa_pkg::reg_addr_t reg_addr,   // debug, 0 selects the pc
    output mips_isa_pkg::word_t     reg_data,
    output mips_isa_pkg::word_t     im_addr,
    input  mips_isa_pkg::word_t     im_data,
    output mips_isa_pkg::word_t     dm_addr,
    output logic                    dm_we,
    output mips_isa_pkg::word_t     dm_wdata,
    output logic                    dm_valid,
    input  logic                    dm_ready,
    input  mips_isa_pkg::word_t     dm_rdata
);
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    word_t     pc_f, rd1_d, rd2_d, rd1_e, rd2_e, imm_e;
    word_t     alu_result_m, write_data_m, result_w;
    logic [op_bits-1:0] op_d;
    logic [fn_bits-1:0] funct_d;
    reg_addr_t rs_d, rt_d, rs_e, rt_e, rd_e;
    reg_addr_t write_reg_e, write_reg_m, write_reg_w;

    // hazard unit outputs
    logic      regs_equal_d, pc_src_d, mem_busy;
    logic      stall_fd, flush_d, flush_e, stall_emw;
    logic      fwd_a_d, fwd_b_d;
    fwd_e_t    fwd_a_e, fwd_b_e;

    // control per stage
    logic      reg_write_d, mem_to_reg_d, mem_write_d, alu_src_d, reg_dst_d;
    alu_op_t   alu_op_d;
    logic      reg_write_e, mem_to_reg_e, mem_write_e, alu_src_e, reg_dst_e;
    alu_op_t   alu_op_e;
    logic      reg_write_m, mem_to_reg_m, mem_write_m;
    logic      reg_write_w;

    pcpu_control pcpu_control_inst (.*);

    pcpu_fetch_decode #(
        .reset_pc (reset_pc)
    ) pcpu_fetch_decode_inst (.*);

    pcpu_regfile pcpu_regfile_inst (
        .clk      (clk),
        .a0       (reg_addr),
        .a1       (rs_d),
        .a2       (rt_d),
        .a3       (write_reg_w),
        .wd3      (result_w),
        .we3      (reg_write_w),
        .rd1      (rd1_d),
        .rd2      (rd2_d),
        .pc_f     (pc_f),
        .reg_data (reg_data)
    );

    pcpu_execute pcpu_execute_inst (.*);

    pcpu_mem_wb pcpu_mem_wb_inst (.*);

endmodule

`default_nettype wire

// ==== tests/pcpu_properties.sv ====
// data memory bus rules of the core, bound into pcpu_top
`timescale 1ns/1ps
`default_nettype none

module pcpu_properties (
    input logic                clk,
    input logic                reset,
    input logic                dm_valid,
    input logic                dm_ready,
    input logic                dm_we,
    input mips_isa_pkg::word_t dm_addr,
    input mips_isa_pkg::word_t dm_wdata
);

    // ********************
    // reset leaves no request on the bus
    valid_low_after_reset: assert property (@(posedge clk) reset |=> !dm_valid)
        else $error("dm_valid high in the cycle after reset");

    we_needs_valid: assert property (@(posedge clk) disable iff (reset) dm_we |-> dm_valid)
        else $error("dm_we high without dm_valid");

    // a waiting request stays unchanged until dm_ready
    hold_while_waiting: assert property (@(posedge clk) disable iff (reset)
        dm_valid && !dm_ready |=>
            dm_valid && $stable(dm_addr) && $stable(dm_we) && $stable(dm_wdata))
        else $error("data request changed while dm_ready was low");

endmodule

bind pcpu_top pcpu_properties pcpu_properties_inst (
    .clk      (clk),
    .reset    (reset),
    .dm_valid (dm_valid),
    .dm_ready (dm_ready),
    .dm_we    (dm_we),
    .dm_addr  (dm_addr),
    .dm_wdata (dm_wdata)
);

`default_nettype wire

// ==== tests/pcpu_tb.sv ====
// random programs run on the core and on an in-order ISA model
// rom holds one program from address 0, ram keeps its contents across programs
// registers 1 to 7 are read through the debug port once the halt loop is reached
`timescale 1ns/1ps
`default_nettype none

module pcpu_tb;
    import mips_isa_pkg::*;

    localparam word_t reset_pc        = 32'h0000_0000;
    localparam int    clk_period      = 8;
    localparam int    reset_cycles    = 10;
    localparam int    n_programs      = 6;
    localparam int    body_len        = 48;
    localparam int    prog_len        = 7 + body_len + 1;   // init, body, halt
    localparam int    watchdog_cycles = n_programs * (prog_len * 20 + 2 * reset_cycles);

    logic      clk, reset, dm_we, dm_valid, dm_ready;
    reg_addr_t reg_addr;
    word_t     reg_data, im_addr, im_data, dm_addr, dm_wdata, dm_rdata;

    word_t  rom [0:255];
    word_t  ram [0:63];          // answers the DUT
    word_t  model_ram [0:63];
    word_t  model_reg [0:31];
    word_t  exp_addr_q [$];      // store log of the model, in program order
    word_t  exp_data_q [$];
    integer prog_seed = 32'h436f_a86d;
    integer mem_seed  = 32'h436f_a86d ^ 32'h0000_ffff;   // dm_ready delays

    pcpu_top #(
        .reset_pc (reset_pc)
    ) pcpu_top_inst (
        .clk      (clk),
        .reset    (reset),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_valid (dm_valid),
        .dm_ready (dm_ready),
        .dm_rdata (dm_rdata)
    );

    assign im_data = rom[im_addr[7:0]];   // same cycle answer

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic int pick(input int n);
        return int'($unsigned($random(prog_seed)) % n);
    endfunction

    function automatic word_t ram_fill(input int idx);
        return (idx * 32'h0104_1041) ^ 32'hc3a5_0f96;
    endfunction

    // ********************
    // program generator
    task automatic gen_program(input int halt_idx);
        int          i, kind, off;
        reg_addr_t   rs, rt, rd;
        logic [15:0] imm;
        for (i = 0; i < 256; i++)
            rom[i] = '0;
        for (i = 1; i <= 7; i++)
            rom[i - 1] = {op_addiu, 5'd0, 5'(i), 16'(pick(65536))};   // known start values
        for (i = 7; i < halt_idx; i++) begin
            kind = pick(12);
            rs   = 5'(pick(8));
            rt   = 5'(pick(8));
            rd   = 5'(pick(8));       // r0 as a target now and then
            imm  = 16'(pick(65536));
            off  = 1 + pick(3);
            if (off > halt_idx - i - 1)
                off = halt_idx - i - 1;
            if (pick(2) != 0)
                rt = (kind >= 10) ? rs : rt;   // more taken beq
            case (kind)
                0:       rom[i] = {op_rtype, rs, rt, rd, 5'd0, fn_addu};
                1:       rom[i] = {op_rtype, rs, rt, rd, 5'd0, fn_subu};
                2:       rom[i] = {op_rtype, rs, rt, rd, 5'd0, fn_and};
                3:       rom[i] = {op_rtype, rs, rt, rd, 5'd0, fn_or};
                4:       rom[i] = {op_rtype, rs, rt, rd, 5'd0, fn_slt};
                5:       rom[i] = {op_addiu, rs, rt, imm};
                6:       rom[i] = {op_lui, 5'd0, rt, imm};
                7, 8:    rom[i] = {op_lw, 5'd0, rt, 8'd0, 6'(pick(64)), 2'b00};
                9:       rom[i] = {op_sw, 5'd0, rt, 8'd0, 6'(pick(64)), 2'b00};
                10:      rom[i] = {op_beq, rs, rt, 16'(off)};
                default: rom[i] = {op_bne, rs, rt, 16'(off)};
            endcase
        end
        rom[halt_idx] = {op_beq, 5'd0, 5'd0, 16'hffff};   // beq r0,r0,-1
    endtask

    // ********************
    // ISA model, one instruction at a time, no delay slot
    task automatic run_model(input int halt_idx);
        int        pc;
        word_t     w, a, b, simm, res, addr;
        logic      wr;
        reg_addr_t dst;
        pc = int'(reset_pc >> 2);
        while (pc != halt_idx) begin
            w    = rom[pc];
            a    = model_reg[w[25:21]];
            b    = model_reg[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            addr = a + simm;
            res  = '0;
            wr   = 1'b1;
            dst  = w[20:16];
            pc   = pc + 1;
            case (w[31:26])
                op_rtype: begin
                    dst = w[15:11];
                    case (w[5:0])
                        fn_addu: res = a + b;
                        fn_subu: res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                op_addiu: res = addr;
                op_lui:   res = {w[15:0], 16'h0000};
                op_lw:    res = model_ram[addr[7:2]];
                op_sw: begin
                    wr = 1'b0;
                    model_ram[addr[7:2]] = b;
                    exp_addr_q.push_back(addr);
                    exp_data_q.push_back(b);
                end
                op_beq, op_bne: begin
                    wr = 1'b0;
                    if ((a == b) == (w[31:26] == op_beq))
                        pc = pc + int'(simm);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0)
                model_reg[dst] = res;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        fail_run("timeout, a program never reached its halt loop");
    end

    // ********************
    // data memory with 0 to 3 wait cycles per access
    initial begin
        int   wait_left;
        logic in_access;
        dm_ready  = 1'b0;
        dm_rdata  = '0;
        in_access = 1'b0;
        wait_left = 0;
        for (int i = 0; i < 64; i++)
            ram[i] = ram_fill(i);
        forever begin
            @(negedge clk);
            dm_ready = 1'b0;
            if (dm_valid !== 1'b1) begin
                in_access = 1'b0;
            end else begin
                if (dm_addr[31:8] != 24'd0 || dm_addr[1:0] != 2'd0)
                    fail_run("data access outside the 64-word RAM");
                if (!in_access) begin
                    wait_left = int'($unsigned($random(mem_seed)) % 4);
                    in_access = 1'b1;
                end
                if (wait_left == 0) begin           // completes on the next rising edge
                    dm_ready  = 1'b1;
                    in_access = 1'b0;
                    if (dm_we !== 1'b1) begin
                        dm_rdata = ram[dm_addr[7:2]];
                    end else if (exp_addr_q.size() == 0) begin
                        fail_run("store that the model never makes");
                    end else begin
                        check_value("dm_addr", dm_addr, exp_addr_q.pop_front());
                        check_value("dm_wdata", dm_wdata, exp_data_q.pop_front());
                        ram[dm_addr[7:2]] = dm_wdata;
                    end
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    initial begin
        int    settled, halt_idx;
        word_t halt_addr;
        reset    = 1'b1;
        reg_addr = '0;
        for (int i = 0; i < 32; i++)
            model_reg[i] = '0;
        for (int i = 0; i < 64; i++)
            model_ram[i] = ram_fill(i);
        halt_idx  = 7 + body_len;
        halt_addr = reset_pc + word_t'(halt_idx * 4);
        for (int prog = 0; prog < n_programs; prog++) begin
            @(negedge clk);
            reset = 1'b1;
            gen_program(halt_idx);
            run_model(halt_idx);
            repeat (reset_cycles) @(negedge clk);
            reset = 1'b0;
            check_value("reg_data (pc)", reg_data, reset_pc);
            check_value("dm_valid", {31'b0, dm_valid}, 32'd0);
            // halt loop swaps the pc between the beq and its flushed successor
            settled = 0;
            while (settled < 8) begin
                @(negedge clk);
                if ((reg_data == halt_addr || reg_data == halt_addr + 32'd4) && !dm_valid)
                    settled = settled + 1;
                else
                    settled = 0;
            end
            for (int r = 1; r < 8; r++) begin
                reg_addr = r[4:0];
                @(negedge clk);
                check_value($sformatf("reg_data (r%0d)", r), reg_data, model_reg[r]);
            end
            reg_addr = '0;
            if (exp_addr_q.size() != 0)
                fail_run("stores of the model never reached the data memory");
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/mips_isa_pkg.sv
logic/pipe_ctrl_pkg.sv
logic/pcpu_control.sv
logic/pcpu_fetch_decode.sv
logic/pcpu_regfile.sv
logic/pcpu_execute.sv
logic/pcpu_mem_wb.sv
logic/pcpu_top.sv
tests/pcpu_properties.sv
tests/pcpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the core with its testbench and runs it, exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module pcpu_tb -Mdir obj_dir
./obj_dir/Vpcpu_tb
